//--- hw/l2_pkg.sv
`default_nettype none

package l2_pkg;

    // default cache geometry
    parameter int L2_TAG_W   = 18;
    parameter int L2_INDEX_W = 8;
    parameter int L2_WAYS    = 4;

    // controller sequencing
    // S_DONE is the single cycle in which ready is high
    typedef enum logic [2:0]
    {
        S_IDLE       = 3'd0,
        S_LOOKUP     = 3'd1,
        S_DONE       = 3'd2,
        S_WRITE_BACK = 3'd3,
        S_ALLOCATE   = 3'd4
    } l2_state_t;

endpackage

`default_nettype wire

//--- hw/l2_tag_store.sv
`timescale 1ns/10ps
`default_nettype none

module l2_tag_store
    import l2_pkg::*;
#(
    parameter int TAG_W   = L2_TAG_W,
    parameter int INDEX_W = L2_INDEX_W,
    parameter int WAYS    = L2_WAYS
)
(
    input  logic                     clk,
    input  logic                     nrst,
    input  logic [INDEX_W-1:0]       index,
    input  logic [TAG_W-1:0]         tag,
    input  logic [$clog2(WAYS)-1:0]  sel_way,
    input  logic                     fill,
    input  logic                     mark_dirty,
    input  logic                     invalidate_all,
    output logic                     hit,
    output logic [$clog2(WAYS)-1:0]  hit_way,
    output logic [WAYS-1:0]          set_valid,
    output logic [TAG_W-1:0]         sel_tag,
    output logic                     sel_dirty
);

    localparam int WAY_W = $clog2(WAYS);
    localparam int SETS  = 1 << INDEX_W;

    logic [TAG_W-1:0] tag_mem [SETS][WAYS];
    logic [WAYS-1:0]  valid_q [SETS];
    logic [WAYS-1:0]  dirty_q [SETS];
    logic [WAYS-1:0]  match;

    // parallel compare over all ways of the set
    always_comb
    begin
        for (int w = 0; w < WAYS; w++)
        begin
            match[w] = valid_q[index][w] && (tag_mem[index][w] == tag);
        end
    end

    assign hit = |match;

    // at most one way matches, so a simple encode is enough
    always_comb
    begin
        hit_way = '0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (match[w])
            begin
                hit_way = WAY_W'(w);
            end
        end
    end

    assign set_valid = valid_q[index];
    assign sel_tag   = tag_mem[index][sel_way];
    assign sel_dirty = dirty_q[index][sel_way];

    always_ff @(posedge clk)
    begin
        if (fill)
        begin
            tag_mem[index][sel_way] <= tag;
        end
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (invalidate_all)
        begin
            // dirty contents are dropped, nothing is written back
            for (int s = 0; s < SETS; s++)
            begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
        end
        else if (fill)
        begin
            valid_q[index][sel_way] <= 1'b1;
            dirty_q[index][sel_way] <= 1'b0;
        end
        else if (mark_dirty)
        begin
            dirty_q[index][sel_way] <= 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- hw/l2_replacement.sv
`timescale 1ns/10ps
`default_nettype none

module l2_replacement
    import l2_pkg::*;
#(
    parameter int INDEX_W = L2_INDEX_W,
    parameter int WAYS    = L2_WAYS
)
(
    input  logic                     clk,
    input  logic                     nrst,
    input  logic [INDEX_W-1:0]       index,
    input  logic [WAYS-1:0]          set_valid,
    input  logic                     touch,
    input  logic [$clog2(WAYS)-1:0]  touch_way,
    output logic [$clog2(WAYS)-1:0]  victim_way
);

    localparam int WAY_W = $clog2(WAYS);
    localparam int AGE_W = $clog2(WAYS);
    localparam int SETS  = 1 << INDEX_W;

    // age 0 is most recently used, WAYS-1 is least recently used
    logic [AGE_W-1:0] age_q [SETS][WAYS];
    logic [AGE_W-1:0] touch_age;
    logic             invalid_found;

    assign touch_age = age_q[index][touch_way];

    // fill empty ways first, lowest number wins
    always_comb
    begin
        victim_way    = '0;
        invalid_found = 1'b0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (!invalid_found && !set_valid[w])
            begin
                victim_way    = WAY_W'(w);
                invalid_found = 1'b1;
            end
        end
        if (!invalid_found)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                if (age_q[index][w] == AGE_W'(WAYS - 1))
                begin
                    victim_way = WAY_W'(w);
                end
            end
        end
    end

    // ages stay a permutation of 0..WAYS-1 within each set
    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            for (int s = 0; s < SETS; s++)
            begin
                for (int w = 0; w < WAYS; w++)
                begin
                    age_q[s][w] <= AGE_W'(w);
                end
            end
        end
        else if (touch)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                if (WAY_W'(w) == touch_way)
                begin
                    age_q[index][w] <= '0;
                end
                else if (age_q[index][w] < touch_age)
                begin
                    age_q[index][w] <= age_q[index][w] + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- hw/l2_ctrl_fsm.sv
`timescale 1ns/10ps
`default_nettype none

module l2_ctrl_fsm
    import l2_pkg::*;
#(
    parameter int TAG_W   = L2_TAG_W,
    parameter int INDEX_W = L2_INDEX_W,
    parameter int WAYS    = L2_WAYS
)
(
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     req_read,
    input  logic                     req_write,
    input  logic [TAG_W-1:0]         req_tag,
    input  logic [INDEX_W-1:0]       req_index,
    input  logic                     invalidate,
    input  logic                     mem_ready,
    output logic                     ready,
    output logic                     miss,
    output logic                     update,
    output logic                     refill,
    output logic [$clog2(WAYS)-1:0]  way,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic [TAG_W-1:0]         mem_tag,
    output logic [INDEX_W-1:0]       mem_index,
    output logic                     fill,
    output logic                     mark_dirty,
    output logic                     invalidate_all,
    output logic [$clog2(WAYS)-1:0]  sel_way,
    input  logic                     hit,
    input  logic [$clog2(WAYS)-1:0]  hit_way,
    input  logic [WAYS-1:0]          set_valid,
    input  logic [TAG_W-1:0]         sel_tag,
    input  logic                     sel_dirty,
    output logic                     touch,
    input  logic [$clog2(WAYS)-1:0]  victim_way
);

    localparam int WAY_W = $clog2(WAYS);

    l2_state_t        state_q;
    l2_state_t        state_d;
    logic [WAY_W-1:0] pick_way;
    logic             in_lookup;

    assign in_lookup = (state_q == S_LOOKUP);

    // hit way on a hit, replacement victim otherwise
    assign pick_way = hit ? hit_way : victim_way;

    // lookup steers the store to the candidate way, later states use the held one
    assign sel_way = in_lookup ? pick_way : way;

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            S_IDLE:
            begin
                if (invalidate)
                begin
                    state_d = S_IDLE;
                end
                else if (req_read || req_write)
                begin
                    state_d = S_LOOKUP;
                end
            end
            S_LOOKUP:
            begin
                if (hit)
                begin
                    state_d = S_DONE;
                end
                else if (set_valid[sel_way] && sel_dirty)
                begin
                    state_d = S_WRITE_BACK;
                end
                else
                begin
                    state_d = S_ALLOCATE;
                end
            end
            S_DONE:
            begin
                state_d = S_IDLE;
            end
            S_WRITE_BACK:
            begin
                if (mem_ready)
                begin
                    state_d = S_ALLOCATE;
                end
            end
            S_ALLOCATE:
            begin
                // refetched line hits on the next lookup
                if (mem_ready)
                begin
                    state_d = S_LOOKUP;
                end
            end
            default:
            begin
                state_d = S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst)
    begin
        if (!nrst)
        begin
            state_q <= S_IDLE;
            ready   <= 1'b0;
            miss    <= 1'b0;
            update  <= 1'b0;
            refill  <= 1'b0;
            way     <= '0;
        end
        else
        begin
            state_q <= state_d;
            ready   <= in_lookup && hit;
            miss    <= in_lookup && !hit;
            update  <= in_lookup && hit && req_write;
            refill  <= (state_q == S_ALLOCATE) && mem_ready;
            if (in_lookup)
            begin
                way <= pick_way;
            end
        end
    end

    // store and age commands
    assign touch          = in_lookup && hit;
    assign mark_dirty     = in_lookup && hit && req_write;
    assign fill           = (state_q == S_ALLOCATE) && mem_ready;
    assign invalidate_all = (state_q == S_IDLE) && invalidate;

    // memory side
    assign mem_write = (state_q == S_WRITE_BACK);
    assign mem_read  = (state_q == S_ALLOCATE);
    assign mem_tag   = mem_write ? sel_tag : req_tag;
    assign mem_index = req_index;

endmodule

`default_nettype wire

//--- hw/l2_controller.sv
`timescale 1ns/10ps
`default_nettype none

module l2_controller
    import l2_pkg::*;
#(
    parameter int TAG_W   = L2_TAG_W,
    parameter int INDEX_W = L2_INDEX_W,
    parameter int WAYS    = L2_WAYS
)
(
    input  logic                     clk,
    input  logic                     nrst,
    input  logic                     req_read,
    input  logic                     req_write,
    input  logic [TAG_W-1:0]         req_tag,
    input  logic [INDEX_W-1:0]       req_index,
    input  logic                     invalidate,
    output logic                     ready,
    output logic                     miss,
    output logic                     update,
    output logic                     refill,
    output logic [$clog2(WAYS)-1:0]  way,
    output logic                     mem_read,
    output logic                     mem_write,
    output logic [TAG_W-1:0]         mem_tag,
    output logic [INDEX_W-1:0]       mem_index,
    input  logic                     mem_ready
);

    localparam int WAY_W = $clog2(WAYS);

    logic             fill;
    logic             mark_dirty;
    logic             invalidate_all;
    logic [WAY_W-1:0] sel_way;
    logic             hit;
    logic [WAY_W-1:0] hit_way;
    logic [WAYS-1:0]  set_valid;
    logic [TAG_W-1:0] sel_tag;
    logic             sel_dirty;
    logic             touch;
    logic [WAY_W-1:0] victim_way;

    l2_ctrl_fsm #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W),
        .WAYS    (WAYS)
    ) u_fsm (
        .clk            (clk),
        .nrst           (nrst),
        .req_read       (req_read),
        .req_write      (req_write),
        .req_tag        (req_tag),
        .req_index      (req_index),
        .invalidate     (invalidate),
        .mem_ready      (mem_ready),
        .ready          (ready),
        .miss           (miss),
        .update         (update),
        .refill         (refill),
        .way            (way),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .mem_tag        (mem_tag),
        .mem_index      (mem_index),
        .fill           (fill),
        .mark_dirty     (mark_dirty),
        .invalidate_all (invalidate_all),
        .sel_way        (sel_way),
        .hit            (hit),
        .hit_way        (hit_way),
        .set_valid      (set_valid),
        .sel_tag        (sel_tag),
        .sel_dirty      (sel_dirty),
        .touch          (touch),
        .victim_way     (victim_way)
    );

    // the store is looked up directly with the held request
    l2_tag_store #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W),
        .WAYS    (WAYS)
    ) u_tag_store (
        .clk            (clk),
        .nrst           (nrst),
        .index          (req_index),
        .tag            (req_tag),
        .sel_way        (sel_way),
        .fill           (fill),
        .mark_dirty     (mark_dirty),
        .invalidate_all (invalidate_all),
        .hit            (hit),
        .hit_way        (hit_way),
        .set_valid      (set_valid),
        .sel_tag        (sel_tag),
        .sel_dirty      (sel_dirty)
    );

    l2_replacement #(
        .INDEX_W (INDEX_W),
        .WAYS    (WAYS)
    ) u_replacement (
        .clk        (clk),
        .nrst       (nrst),
        .index      (req_index),
        .set_valid  (set_valid),
        .touch      (touch),
        .touch_way  (sel_way),
        .victim_way (victim_way)
    );

endmodule

`default_nettype wire

//--- tb/l2_controller_properties.sv
`timescale 1ns/10ps
`default_nettype none

module l2_controller_properties
    import l2_pkg::*;
(
    input logic clk,
    input logic nrst,
    input logic ready,
    input logic update,
    input logic refill,
    input logic mem_read,
    input logic mem_write,
    input logic mem_ready
);

    // write-back and refill never overlap
    a_one_command: assert property (@(posedge clk) disable iff (!nrst)
        !(mem_read && mem_write))
        else $error("mem_read and mem_write high together");

    a_ready_pulse: assert property (@(posedge clk) disable iff (!nrst)
        ready |=> !ready)
        else $error("ready high for two cycles");

    a_update_with_ready: assert property (@(posedge clk) disable iff (!nrst)
        update |-> ready)
        else $error("update without ready");

    // refill is registered from the memory answer
    a_refill_after_mem: assert property (@(posedge clk) disable iff (!nrst)
        refill |-> $past(mem_ready))
        else $error("refill without a preceding mem_ready");

endmodule

bind l2_controller l2_controller_properties u_properties
(
    .clk       (clk),
    .nrst      (nrst),
    .ready     (ready),
    .update    (update),
    .refill    (refill),
    .mem_read  (mem_read),
    .mem_write (mem_write),
    .mem_ready (mem_ready)
);

`default_nettype wire

//--- tb/tb_l2_controller.sv
`timescale 1ns/10ps
`default_nettype none

module tb_l2_controller;

    localparam int TAG_W      = 18;
    localparam int INDEX_W    = 2;
    localparam int WAYS       = 4;
    localparam int WAY_W      = $clog2(WAYS);
    localparam int SETS       = 1 << INDEX_W;
    localparam int NUM_TRANS  = 400;
    localparam int WAIT_LIMIT = 60;
    localparam int POOL_SIZE  = 6;

    localparam int SIG_READY = 0;
    localparam int SIG_WRITE = 1;
    localparam int SIG_READ  = 2;
    localparam int SIG_FILL  = 3;

    logic               clk;
    logic               nrst;
    logic               req_read;
    logic               req_write;
    logic [TAG_W-1:0]   req_tag;
    logic [INDEX_W-1:0] req_index;
    logic               invalidate;
    logic               ready;
    logic               miss;
    logic               update;
    logic               refill;
    logic [WAY_W-1:0]   way;
    logic               mem_read;
    logic               mem_write;
    logic [TAG_W-1:0]   mem_tag;
    logic [INDEX_W-1:0] mem_index;
    logic               mem_ready;

    // reference model of the tag store and LRU ages
    logic [TAG_W-1:0] m_tag [SETS][WAYS];
    logic             m_valid [SETS][WAYS];
    logic             m_dirty [SETS][WAYS];
    int               m_age [SETS][WAYS];

    logic [TAG_W-1:0] tag_pool [POOL_SIZE];
    int               seed;
    bit               saw_write;

    l2_controller #(
        .TAG_W   (TAG_W),
        .INDEX_W (INDEX_W),
        .WAYS    (WAYS)
    ) u_dut (
        .clk        (clk),
        .nrst       (nrst),
        .req_read   (req_read),
        .req_write  (req_write),
        .req_tag    (req_tag),
        .req_index  (req_index),
        .invalidate (invalidate),
        .ready      (ready),
        .miss       (miss),
        .update     (update),
        .refill     (refill),
        .way        (way),
        .mem_read   (mem_read),
        .mem_write  (mem_write),
        .mem_tag    (mem_tag),
        .mem_index  (mem_index),
        .mem_ready  (mem_ready)
    );

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp)
        begin
            $display("FAIL %s: got 0x%0h, expected 0x%0h", name, got, exp);
            $display("SIMULATION FAILED");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "%s", what);
    endtask

    function automatic int rand_below(input int n);
        int r;
        r = $random(seed);
        return int'($unsigned(r) % $unsigned(n));
    endfunction

    // outputs read here still hold the values of the cycle that just ended
    task automatic next_edge();
        @(posedge clk);
        if (mem_write)
        begin
            saw_write = 1'b1;
        end
    endtask

    function automatic logic probe(input int which);
        case (which)
            SIG_READY: probe = ready;
            SIG_WRITE: probe = mem_write;
            SIG_READ:  probe = mem_read;
            default:   probe = refill;
        endcase
    endfunction

    task automatic wait_until(input int which, input string name);
        int n;
        n = 0;
        while (!probe(which))
        begin
            next_edge();
            n++;
            if (n > WAIT_LIMIT)
            begin
                fail_run({"timeout waiting for ", name});
            end
        end
    endtask

    task automatic respond_mem();
        int delay;
        delay = rand_below(6);
        repeat (delay) next_edge();
        mem_ready <= 1'b1;
        next_edge();
        mem_ready <= 1'b0;
    endtask

    // lowest invalid way first, else the oldest one
    function automatic int model_victim(input int idx);
        int  v;
        bit  found;
        v = 0;
        found = 1'b0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (!found && !m_valid[idx][w])
            begin
                v = w;
                found = 1'b1;
            end
        end
        for (int w = 0; w < WAYS; w++)
        begin
            if (!found && m_age[idx][w] == WAYS - 1)
            begin
                v = w;
            end
        end
        return v;
    endfunction

    task automatic model_touch(input int idx, input int tw);
        int a;
        a = m_age[idx][tw];
        for (int w = 0; w < WAYS; w++)
        begin
            if (w == tw)
            begin
                m_age[idx][w] = 0;
            end
            else if (m_age[idx][w] < a)
            begin
                m_age[idx][w] = m_age[idx][w] + 1;
            end
        end
    endtask

    task automatic do_invalidate();
        next_edge();
        invalidate <= 1'b1;
        next_edge();
        invalidate <= 1'b0;
        for (int s = 0; s < SETS; s++)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
            end
        end
    endtask

    task automatic run_access(input bit is_write, input int tsel, input int idx);
        logic [TAG_W-1:0] tag;
        logic [TAG_W-1:0] wb_tag;
        bit               exp_hit;
        bit               exp_wb;
        int               exp_way;
        int               cycles;

        tag = tag_pool[tsel];
        exp_hit = 1'b0;
        exp_way = 0;
        for (int w = 0; w < WAYS; w++)
        begin
            if (m_valid[idx][w] && m_tag[idx][w] == tag)
            begin
                exp_hit = 1'b1;
                exp_way = w;
            end
        end
        if (!exp_hit)
        begin
            exp_way = model_victim(idx);
        end
        exp_wb = !exp_hit && m_valid[idx][exp_way] && m_dirty[idx][exp_way];
        wb_tag = m_tag[idx][exp_way];
        saw_write = 1'b0;

        next_edge();
        req_read  <= !is_write;
        req_write <= is_write;
        req_tag   <= tag;
        req_index <= INDEX_W'(idx);

        // ready on a hit, miss otherwise, both at the same point
        cycles = 0;
        do
        begin
            next_edge();
            cycles++;
            if (cycles > WAIT_LIMIT)
            begin
                fail_run("timeout waiting for the lookup result");
            end
        end
        while (!ready && !miss);
        check_value("lookup_latency", 32'(cycles), 32'd3);
        check_value("miss", 32'(miss), 32'(!exp_hit));

        if (!exp_hit)
        begin
            if (exp_wb)
            begin
                wait_until(SIG_WRITE, "mem_write");
                check_value("mem_tag", 32'(mem_tag), 32'(wb_tag));
                check_value("mem_index", 32'(mem_index), 32'(idx));
                respond_mem();
            end
            wait_until(SIG_READ, "mem_read");
            check_value("mem_tag", 32'(mem_tag), 32'(tag));
            check_value("mem_index", 32'(mem_index), 32'(idx));
            respond_mem();
            wait_until(SIG_FILL, "refill");
            wait_until(SIG_READY, "ready after refill");
            m_tag[idx][exp_way]   = tag;
            m_valid[idx][exp_way] = 1'b1;
            m_dirty[idx][exp_way] = 1'b0;
        end

        check_value("way", 32'(way), 32'(exp_way));
        check_value("update", 32'(update), 32'(is_write));
        check_value("mem_write_issued", 32'(saw_write), 32'(exp_wb));
        model_touch(idx, exp_way);
        if (is_write)
        begin
            m_dirty[idx][exp_way] = 1'b1;
        end
        req_read  <= 1'b0;
        req_write <= 1'b0;
    endtask

    initial
    begin
        int op;
        int tsel;
        int idx;
        int gap;

        seed       = 32'hce5b8fd9;
        nrst       = 1'b0;
        req_read   = 1'b0;
        req_write  = 1'b0;
        req_tag    = '0;
        req_index  = '0;
        invalidate = 1'b0;
        mem_ready  = 1'b0;
        saw_write  = 1'b0;

        for (int i = 0; i < POOL_SIZE; i++)
        begin
            tag_pool[i] = TAG_W'(32'h2a5c3 + 32'(i) * 32'h1357);
        end
        for (int s = 0; s < SETS; s++)
        begin
            for (int w = 0; w < WAYS; w++)
            begin
                m_tag[s][w]   = '0;
                m_valid[s][w] = 1'b0;
                m_dirty[s][w] = 1'b0;
                m_age[s][w]   = w;
            end
        end

        repeat (8) @(posedge clk);
        nrst <= 1'b1;
        repeat (2) @(posedge clk);

        for (int t = 0; t < NUM_TRANS; t++)
        begin
            if (rand_below(20) == 0)
            begin
                do_invalidate();
            end
            op   = rand_below(2);
            tsel = rand_below(POOL_SIZE);
            idx  = rand_below(SETS);
            run_access(op == 1, tsel, idx);
            gap = rand_below(3);
            repeat (gap) next_edge();
        end

        $display("SIMULATION PASSED");
        $finish;
    end

endmodule

`default_nettype wire

//--- files.f
hw/l2_pkg.sv
hw/l2_tag_store.sv
hw/l2_replacement.sv
hw/l2_ctrl_fsm.sv
hw/l2_controller.sv
tb/l2_controller_properties.sv
tb/tb_l2_controller.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the L2 controller testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
    --timescale 1ns/10ps \
    --top-module tb_l2_controller \
    -f files.f \
    -o sim_l2_controller

./obj_dir/sim_l2_controller
